// File: compile.f
logic/rv_exec_pkg.sv
logic/alu_control_unit.sv
logic/alu.sv
logic/branch_compare.sv
logic/exec_writeback.sv
logic/exec_stage.sv
test/exec_stage_tb.sv

// File: Makefile
SIM := obj_dir/Vexec_stage_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module exec_stage_tb \
		-Mdir obj_dir -f compile.f
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// File: test/exec_stage_tb.sv
module exec_stage_tb;

    import rv_exec_pkg::*;

    // expected response of one instruction
    typedef struct packed {
        logic      legal;
        logic      branch;
        logic      we;
        logic      taken;
        reg_addr_t rd;
        xword_t    value;
        xword_t    target;
    } expect_t;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      in_valid;
    opcode_t   opcode;
    funct3_t   funct3;
    funct7_t   funct7;
    xword_t    rs1_value;
    xword_t    rs2_value;
    xword_t    imm;
    xword_t    pc;
    reg_addr_t rd_addr;
    logic      wb_valid;
    logic      wb_we;
    reg_addr_t wb_rd;
    xword_t    wb_value;
    logic      branch_taken;
    xword_t    branch_target;
    logic      illegal_op;

    integer    seed;
    // results still owed by the stage, oldest first
    expect_t   pending [$];

    // sign bit, all ones, shift limits
    xword_t corners [5] = '{32'h0, 32'h1, 32'd31, 32'h8000_0000, 32'hFFFF_FFFF};
    // equal, less, greater, then signed and unsigned disagree
    xword_t br_lhs [5] = '{32'd5, 32'd1, 32'd2, 32'hFFFF_FFFF, 32'd1};
    xword_t br_rhs [5] = '{32'd5, 32'd2, 32'd1, 32'd1, 32'hFFFF_FFFF};

    always #5 clk = ~clk;

    exec_stage i_exec_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .opcode        (opcode),
        .funct3        (funct3),
        .funct7        (funct7),
        .rs1_value     (rs1_value),
        .rs2_value     (rs2_value),
        .imm           (imm),
        .pc            (pc),
        .rd_addr       (rd_addr),
        .wb_valid      (wb_valid),
        .wb_we         (wb_we),
        .wb_rd         (wb_rd),
        .wb_value      (wb_value),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .illegal_op    (illegal_op)
    );

    // rv32i rules for op, op-imm and branch, written from the spec
    function automatic expect_t model(input opcode_t op, input funct3_t f3,
                                      input funct7_t f7, input xword_t a,
                                      input xword_t b, input xword_t im,
                                      input xword_t p, input reg_addr_t rd);
        expect_t e;
        xword_t  opb;
        logic    alt;
        e   = '0;
        alt = (f7 == F7_ALT);
        opb = (op == OPC_OP_IMM) ? im : b;
        e.rd = rd;
        case (op)
            OPC_OP:
                e.legal = (f7 == F7_BASE) || (alt && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA));
            OPC_OP_IMM:
            begin
                // funct7 only matters for the shifts
                if (f3 == F3_SLL)
                    e.legal = (f7 == F7_BASE);
                else if (f3 == F3_SRL_SRA)
                    e.legal = (f7 == F7_BASE) || alt;
                else
                    e.legal = 1'b1;
            end
            OPC_BRANCH:
                e.legal = (f3 != 3'b010) && (f3 != 3'b011);
            default:
                e.legal = 1'b0;
        endcase
        if (op == OPC_BRANCH)
        begin
            e.branch = e.legal;
            e.target = p + im;
            case (f3)
                F3_BEQ:  e.taken = (a == b);
                F3_BNE:  e.taken = (a != b);
                F3_BLT:  e.taken = ($signed(a) < $signed(b));
                F3_BGE:  e.taken = ($signed(a) >= $signed(b));
                F3_BLTU: e.taken = (a < b);
                F3_BGEU: e.taken = (a >= b);
                default: e.taken = 1'b0;
            endcase
            e.taken = e.taken && e.legal;
        end
        else if (op == OPC_OP || op == OPC_OP_IMM)
        begin
            case (f3)
                // only register op may subtract
                F3_ADD_SUB: e.value = (op == OPC_OP && alt) ? a - opb : a + opb;
                F3_SLL:     e.value = a << opb[4:0];
                F3_SLT:     e.value = {31'b0, $signed(a) < $signed(opb)};
                F3_SLTU:    e.value = {31'b0, a < opb};
                F3_XOR:     e.value = a ^ opb;
                F3_SRL_SRA:
                begin
                    // sign fill for sra, zero fill for srl
                    if (alt)
                        e.value = $signed(a) >>> opb[4:0];
                    else
                        e.value = a >> opb[4:0];
                end
                F3_OR:      e.value = a | opb;
                F3_AND:     e.value = a & opb;
            endcase
            e.we = e.legal && (rd != '0);
        end
        return e;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input xword_t expected, input xword_t actual);
        assert (actual === expected)
        else
            stop_on_error($sformatf("MISMATCH at %0t: %s expected %h, got %h",
                                    $time, name, expected, actual));
    endtask

    // strobes must be quiet in a cycle without input
    task automatic check_idle();
        check_value("wb_valid", '0, xword_t'(wb_valid));
        check_value("wb_we", '0, xword_t'(wb_we));
        check_value("branch_taken", '0, xword_t'(branch_taken));
        check_value("illegal_op", '0, xword_t'(illegal_op));
    endtask

    task automatic check_out(input expect_t e);
        check_value("wb_valid", xword_t'(e.legal), xword_t'(wb_valid));
        check_value("illegal_op", xword_t'(!e.legal), xword_t'(illegal_op));
        check_value("wb_we", xword_t'(e.we), xword_t'(wb_we));
        check_value("branch_taken", xword_t'(e.taken), xword_t'(branch_taken));
        // data of an illegal op is not defined, only its pulse
        if (e.legal)
        begin
            check_value("wb_rd", xword_t'(e.rd), xword_t'(wb_rd));
            check_value("wb_value", e.value, wb_value);
            if (e.branch)
                check_value("branch_target", e.target, branch_target);
        end
    endtask

    // present one instruction, called right after a falling edge
    task automatic drive(input opcode_t op, input funct3_t f3, input funct7_t f7,
                         input xword_t a, input xword_t b, input xword_t im,
                         input xword_t p, input reg_addr_t rd);
        opcode    = op;
        funct3    = f3;
        funct7    = f7;
        rs1_value = a;
        rs2_value = b;
        imm       = im;
        pc        = p;
        rd_addr   = rd;
        in_valid  = 1'b1;
        pending.push_back(model(op, f3, f7, a, b, im, p, rd));
    endtask

    task automatic run_one(input opcode_t op, input funct3_t f3, input funct7_t f7,
                           input xword_t a, input xword_t b, input xword_t im,
                           input xword_t p, input reg_addr_t rd);
        int waited;
        drive(op, f3, f7, a, b, im, p, rd);
        @(negedge clk);
        in_valid = 1'b0;
        waited   = 0;
        while (!wb_valid && !illegal_op)
        begin
            if (waited == 4)
                stop_on_error("no wb_valid or illegal_op within 4 cycles of the strobe");
            else
            begin
                @(negedge clk);
                waited++;
            end
        end
        assert (waited == 0)
        else
            stop_on_error("result came later than one cycle after the strobe");
        check_out(pending.pop_front());
        @(negedge clk);
        check_idle();
    endtask

    task automatic check_all_zero();
        check_idle();
        check_value("wb_rd", '0, xword_t'(wb_rd));
        check_value("wb_value", '0, wb_value);
        check_value("branch_target", '0, branch_target);
    endtask

    task automatic test_reset();
        repeat (16) @(negedge clk);
        check_all_zero();
        rst_n = 1'b1;
        // still zero with no strobe after release
        @(negedge clk);
        check_all_zero();
    endtask

    task automatic test_rtype();
        xword_t a;
        xword_t b;
        for (int f = 0; f < 8; f++)
        begin
            for (int alt = 0; alt < 2; alt++)
            begin
                // alt funct7 only for sub and sra
                if (alt == 0 || f == 0 || f == 5)
                begin
                    for (int x = 0; x < 5; x++)
                    begin
                        for (int y = 0; y < 5; y++)
                            run_one(OPC_OP, funct3_t'(f), alt ? F7_ALT : F7_BASE,
                                    corners[x], corners[y], 32'h0, 32'h1000, 5'd7);
                    end
                    for (int n = 0; n < 40; n++)
                    begin
                        a = $random(seed);
                        b = $random(seed);
                        run_one(OPC_OP, funct3_t'(f), alt ? F7_ALT : F7_BASE,
                                a, b, 32'h0, 32'h1000, reg_addr_t'(n + 1));
                    end
                end
            end
        end
    endtask

    task automatic test_opimm();
        xword_t a;
        xword_t b;
        a = $random(seed);
        // rs2 is noise here, op-imm must ignore it
        b = $random(seed);
        // addi whose upper imm bits look like the sub funct7
        run_one(OPC_OP_IMM, F3_ADD_SUB, F7_ALT, a, b, 32'h0000_0400, 32'h100, 5'd1);
        run_one(OPC_OP_IMM, F3_ADD_SUB, F7_BASE, a, b, 32'hFFFF_F800, 32'h104, 5'd2);
        run_one(OPC_OP_IMM, F3_SLT, F7_BASE, 32'd1, b, 32'hFFFF_FFFF, 32'h108, 5'd3);
        run_one(OPC_OP_IMM, F3_SLTU, F7_BASE, 32'd1, b, 32'hFFFF_FFFF, 32'h10C, 5'd4);
        run_one(OPC_OP_IMM, F3_XOR, F7_BASE, a, b, 32'hFFFF_F0F0, 32'h110, 5'd5);
        run_one(OPC_OP_IMM, F3_OR, F7_BASE, a, b, 32'hFFFF_F0F0, 32'h114, 5'd6);
        run_one(OPC_OP_IMM, F3_AND, F7_BASE, a, b, 32'h0000_00F0, 32'h118, 5'd7);
        run_one(OPC_OP_IMM, F3_SLL, F7_BASE, 32'd1, b, 32'd31, 32'h11C, 5'd8);
        // same shamt, funct7 picks logical or arithmetic
        run_one(OPC_OP_IMM, F3_SRL_SRA, F7_BASE, 32'h8000_0000, b, 32'd31, 32'h120, 5'd9);
        run_one(OPC_OP_IMM, F3_SRL_SRA, F7_ALT, 32'h8000_0000, b, 32'h41F, 32'h124, 5'd10);
        run_one(OPC_OP_IMM, F3_SRL_SRA, F7_ALT, a, b, 32'h404, 32'h128, 5'd11);
        // x0 destination, valid without write
        run_one(OPC_OP_IMM, F3_ADD_SUB, F7_BASE, a, b, 32'h7, 32'h12C, 5'd0);
    endtask

    task automatic test_branch();
        xword_t off;
        for (int f = 0; f < 8; f++)
        begin
            if (f != 2 && f != 3)
            begin
                for (int j = 0; j < 5; j++)
                begin
                    // forward offset wraps past the top, backward does not
                    off = (j % 2 == 0) ? 32'h20 : 32'hFFFF_FF00;
                    run_one(OPC_BRANCH, funct3_t'(f), F7_BASE, br_lhs[j], br_rhs[j],
                            off, 32'hFFFF_FFF0, 5'd12);
                end
            end
        end
    endtask

    task automatic test_illegal();
        // load opcode is outside this stage
        run_one(7'b0000011, F3_ADD_SUB, F7_BASE, 32'd1, 32'd2, 32'd4, 32'h200, 5'd1);
        run_one(OPC_OP, F3_XOR, F7_ALT, 32'd1, 32'd2, 32'd0, 32'h204, 5'd2);
        run_one(OPC_OP_IMM, F3_SLL, F7_ALT, 32'd1, 32'd2, 32'h401, 32'h208, 5'd3);
        run_one(OPC_OP_IMM, F3_SLL, 7'b0000001, 32'd1, 32'd2, 32'h021, 32'h20C, 5'd4);
        run_one(OPC_BRANCH, 3'b010, F7_BASE, 32'd1, 32'd1, 32'h10, 32'h210, 5'd0);
    endtask

    // one strobe per cycle, each result checked one cycle later
    task automatic test_back_to_back();
        xword_t a;
        xword_t b;
        for (int i = 0; i < 10; i++)
        begin
            a = $random(seed);
            b = $random(seed);
            case (i % 4)
                0: drive(OPC_OP, funct3_t'(i), F7_BASE, a, b, 32'h0, 32'h300, reg_addr_t'(i + 1));
                1: drive(OPC_BRANCH, F3_BGE, F7_BASE, a, b, 32'h40, 32'h300, 5'd0);
                2: drive(OPC_OP_IMM, F3_SRL_SRA, F7_ALT, a, b, 32'h405, 32'h300, 5'd20);
                default: drive(7'b1101111, F3_ADD_SUB, F7_BASE, a, b, 32'h8, 32'h300, 5'd1);
            endcase
            @(negedge clk);
            check_out(pending.pop_front());
        end
        in_valid = 1'b0;
        @(negedge clk);
        check_idle();
    endtask

    initial
    begin
        seed      = 89;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        opcode    = '0;
        funct3    = '0;
        funct7    = '0;
        rs1_value = '0;
        rs2_value = '0;
        imm       = '0;
        pc        = '0;
        rd_addr   = '0;
        test_reset();
        test_rtype();
        test_opimm();
        test_branch();
        test_illegal();
        test_back_to_back();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: logic/exec_stage.sv
module exec_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  rv_exec_pkg::opcode_t    opcode,
    input  rv_exec_pkg::funct3_t    funct3,
    input  rv_exec_pkg::funct7_t    funct7,
    input  rv_exec_pkg::xword_t     rs1_value,
    input  rv_exec_pkg::xword_t     rs2_value,
    input  rv_exec_pkg::xword_t     imm,
    input  rv_exec_pkg::xword_t     pc,
    input  rv_exec_pkg::reg_addr_t  rd_addr,
    output logic                    wb_valid,
    output logic                    wb_we,
    output rv_exec_pkg::reg_addr_t  wb_rd,
    output rv_exec_pkg::xword_t     wb_value,
    output logic                    branch_taken,
    output rv_exec_pkg::xword_t     branch_target,
    output logic                    illegal_op
);

    import rv_exec_pkg::*;

    alu_op_t       alu_op;
    logic          use_imm;
    instr_class_t  instr_class;
    logic          illegal;
    xword_t        op_b;
    xword_t        alu_result;
    logic          taken;
    xword_t        target;

    // decode, combinational
    alu_control_unit i_alu_control_unit (
        .clk         (clk),
        .opcode      (opcode),
        .funct3      (funct3),
        .funct7      (funct7),
        .alu_op      (alu_op),
        .use_imm     (use_imm),
        .instr_class (instr_class),
        .illegal     (illegal)
    );

    // op-imm takes the immediate, op takes rs2
    assign op_b = use_imm ? imm : rs2_value;

    alu i_alu (
        .alu_op (alu_op),
        .op_a   (rs1_value),
        .op_b   (op_b),
        .result (alu_result)
    );

    // branch path runs beside the alu on the raw operands
    branch_compare i_branch_compare (
        .funct3 (funct3),
        .rs1    (rs1_value),
        .rs2    (rs2_value),
        .pc     (pc),
        .imm    (imm),
        .taken  (taken),
        .target (target)
    );

    // the single register stage of the block
    exec_writeback i_exec_writeback (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .instr_class   (instr_class),
        .illegal       (illegal),
        .rd_addr       (rd_addr),
        .alu_result    (alu_result),
        .taken         (taken),
        .target        (target),
        .wb_valid      (wb_valid),
        .wb_we         (wb_we),
        .wb_rd         (wb_rd),
        .wb_value      (wb_value),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .illegal_op    (illegal_op)
    );

endmodule

// File: logic/exec_writeback.sv
module exec_writeback (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  rv_exec_pkg::instr_class_t  instr_class,
    input  logic                       illegal,
    input  rv_exec_pkg::reg_addr_t     rd_addr,
    input  rv_exec_pkg::xword_t        alu_result,
    input  logic                       taken,
    input  rv_exec_pkg::xword_t        target,
    output logic                       wb_valid,
    output logic                       wb_we,
    output rv_exec_pkg::reg_addr_t     wb_rd,
    output rv_exec_pkg::xword_t        wb_value,
    output logic                       branch_taken,
    output rv_exec_pkg::xword_t        branch_target,
    output logic                       illegal_op
);

    import rv_exec_pkg::*;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wb_valid      <= 1'b0;
            wb_we         <= 1'b0;
            wb_rd         <= '0;
            wb_value      <= '0;
            branch_taken  <= 1'b0;
            branch_target <= '0;
            illegal_op    <= 1'b0;
        end
        else
        begin
            // strobes last one cycle, data holds
            wb_valid     <= 1'b0;
            wb_we        <= 1'b0;
            branch_taken <= 1'b0;
            illegal_op   <= 1'b0;
            if (in_valid)
            begin
                if (illegal)
                    illegal_op <= 1'b1;
                else
                begin
                    wb_valid <= 1'b1;
                    wb_rd    <= rd_addr;
                    case (instr_class)
                        CLASS_ALU:
                        begin
                            // x0 is hardwired, never written
                            wb_we    <= (rd_addr != '0);
                            wb_value <= alu_result;
                        end
                        CLASS_BRANCH:
                        begin
                            wb_value      <= '0;
                            branch_taken  <= taken;
                            branch_target <= target;
                        end
                        default:
                        begin
                            wb_value <= '0;
                        end
                    endcase
                end
            end
        end
    end

    a_valid_xor_illegal: assert property (
        @(posedge clk) disable iff (!rst_n) !(wb_valid && illegal_op)
    );

    a_taken_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n) branch_taken |-> wb_valid
    );

    a_we_not_x0: assert property (
        @(posedge clk) disable iff (!rst_n) wb_we |-> (wb_rd != '0)
    );

endmodule

// File: logic/branch_compare.sv
module branch_compare (
    input  rv_exec_pkg::funct3_t  funct3,
    input  rv_exec_pkg::xword_t   rs1,
    input  rv_exec_pkg::xword_t   rs2,
    input  rv_exec_pkg::xword_t   pc,
    input  rv_exec_pkg::xword_t   imm,
    output logic                  taken,
    output rv_exec_pkg::xword_t   target
);

    import rv_exec_pkg::*;

    logic eq;
    logic lt_s;
    logic lt_u;

    // three base relations, shared by all six branches
    assign eq   = (rs1 == rs2);
    assign lt_s = ($signed(rs1) < $signed(rs2));
    assign lt_u = (rs1 < rs2);

    // pc relative, wraps like the adder in the alu
    assign target = pc + imm;

    always_comb
    begin
        case (funct3)
            F3_BEQ:
                taken = eq;
            F3_BNE:
                taken = !eq;
            F3_BLT:
                taken = lt_s;
            // ge is the negation of lt, equal counts as taken
            F3_BGE:
                taken = !lt_s;
            F3_BLTU:
                taken = lt_u;
            F3_BGEU:
                taken = !lt_u;
            default:
            begin
                // 010 / 011 flagged illegal by the decoder
                taken = 1'b0;
            end
        endcase
    end

endmodule

// File: logic/alu.sv
module alu (
    input  rv_exec_pkg::alu_op_t  alu_op,
    input  rv_exec_pkg::xword_t   op_a,
    input  rv_exec_pkg::xword_t   op_b,
    output rv_exec_pkg::xword_t   result
);

    import rv_exec_pkg::*;

    logic signed [31:0] op_a_signed;
    logic signed [31:0] op_b_signed;
    logic [4:0]         shamt;

    // signed views for slt and sra
    assign op_a_signed = op_a;
    assign op_b_signed = op_b;

    // only the low five bits shift, imm[4:0] for op-imm
    assign shamt = op_b[4:0];

    always_comb
    begin
        case (alu_op)
            ALU_ADD:
            begin
                // carry out dropped, wraps mod 2^32
                result = op_a + op_b;
            end
            ALU_SUB:
            begin
                result = op_a - op_b;
            end
            ALU_SLL:
            begin
                result = op_a << shamt;
            end
            ALU_SLT:
            begin
                // signed compare, result is 0 or 1
                result = (op_a_signed < op_b_signed) ? 32'd1 : 32'd0;
            end
            ALU_SLTU:
            begin
                // unsigned compare
                result = (op_a < op_b) ? 32'd1 : 32'd0;
            end
            ALU_XOR:
            begin
                result = op_a ^ op_b;
            end
            ALU_SRL:
            begin
                // zero fill from the top
                result = op_a >> shamt;
            end
            ALU_SRA:
            begin
                // sign fill from the top
                result = op_a_signed >>> shamt;
            end
            ALU_OR:
            begin
                result = op_a | op_b;
            end
            ALU_AND:
            begin
                result = op_a & op_b;
            end
            default:
            begin
                // unused codes, decoder never emits them
                result = '0;
            end
        endcase
    end

endmodule

// File: logic/alu_control_unit.sv
module alu_control_unit (
    input  logic                       clk,
    input  rv_exec_pkg::opcode_t       opcode,
    input  rv_exec_pkg::funct3_t       funct3,
    input  rv_exec_pkg::funct7_t       funct7,
    output rv_exec_pkg::alu_op_t       alu_op,
    output logic                       use_imm,
    output rv_exec_pkg::instr_class_t  instr_class,
    output logic                       illegal
);

    import rv_exec_pkg::*;

    logic f7_base;
    logic f7_alt;
    logic legal;

    assign f7_base = (funct7 == F7_BASE);
    assign f7_alt  = (funct7 == F7_ALT);

    // funct3 to operation with funct7 at its base value
    function automatic alu_op_t base_op(input funct3_t f3);
        case (f3)
            F3_ADD_SUB: return ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    always_comb
    begin
        alu_op      = ALU_ADD;
        use_imm     = 1'b0;
        instr_class = CLASS_NONE;
        legal       = 1'b0;
        case (opcode)
            OPC_OP:
            begin
                instr_class = CLASS_ALU;
                // alt funct7 only for sub and sra
                if (f7_base)
                begin
                    alu_op = base_op(funct3);
                    legal  = 1'b1;
                end
                else if (f7_alt && funct3 == F3_ADD_SUB)
                begin
                    alu_op = ALU_SUB;
                    legal  = 1'b1;
                end
                else if (f7_alt && funct3 == F3_SRL_SRA)
                begin
                    alu_op = ALU_SRA;
                    legal  = 1'b1;
                end
            end
            OPC_OP_IMM:
            begin
                instr_class = CLASS_ALU;
                use_imm     = 1'b1;
                // addi never subtracts, upper imm bits ignored
                alu_op      = base_op(funct3);
                legal       = 1'b1;
                if (funct3 == F3_SLL)
                    legal = f7_base;
                else if (funct3 == F3_SRL_SRA)
                begin
                    legal = f7_base || f7_alt;
                    if (f7_alt)
                        alu_op = ALU_SRA;
                end
            end
            OPC_BRANCH:
            begin
                instr_class = CLASS_BRANCH;
                // comparator decides, alu op is a don't-use
                alu_op      = ALU_SUB;
                // codes 010 and 011 have no branch
                legal       = (funct3[2:1] != 2'b01);
            end
            default:
            begin
                legal = 1'b0;
            end
        endcase
        if (!legal)
            instr_class = CLASS_NONE;
        illegal = !legal;
    end

    // sub and sra only come from the alt funct7, and op-imm never subtracts
    a_alt_op_needs_f7_alt: assert property (
        @(posedge clk)
            (instr_class == CLASS_ALU && alu_op inside {ALU_SUB, ALU_SRA})
            |-> (f7_alt && !(use_imm && alu_op == ALU_SUB))
    );

endmodule

// File: logic/rv_exec_pkg.sv
package rv_exec_pkg;

    // rv32i data word: operands, immediate, pc, results
    typedef logic [31:0] xword_t;
    // architectural register number
    typedef logic [4:0]  reg_addr_t;

    // instruction fields seen by the execute stage
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // major opcodes handled here
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    // funct7 variants, alt selects sub / sra
    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

    // funct3 codes for op and op-imm
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // funct3 codes for conditional branches
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // alu operations, codes 10..15 unused
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_t;

    // what the writeback does with the result
    typedef enum logic [1:0] {
        CLASS_NONE   = 2'd0,
        CLASS_ALU    = 2'd1,
        CLASS_BRANCH = 2'd2
    } instr_class_t;

endpackage
